/* design/mat_pkg.sv */
`default_nettype none

package mat_pkg;

    //////////////////////////////////////////////////////////////////////
    // element and row types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0]  elem_t;     // signed q16.16
    typedef logic [127:0] row_t;      // elem 0 in bits 127..96
    typedef logic [1:0]   row_idx_t;  // row 0 is the first row
    typedef logic         mode_t;     // stack select

    localparam mode_t mode_mv = 1'b0; // modelview
    localparam mode_t mode_pj = 1'b1; // projection

    //////////////////////////////////////////////////////////////////////
    // command opcodes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_load_identity = 3'd0,  // top <= I
        op_load          = 3'd1,  // top <= four streamed rows
        op_push          = 3'd2,  // duplicate top one level up
        op_pop           = 3'd3,  // drop top
        op_mult          = 3'd4   // top <= top * streamed matrix
    } mat_op_t;

    // fixed point constants
    localparam elem_t q_one  = 32'h0001_0000;  // 1.0
    localparam elem_t q_zero = 32'h0000_0000;

    // identity, 1.0 on the diagonal
    localparam row_t ident_row_0 = {q_one,  q_zero, q_zero, q_zero};
    localparam row_t ident_row_1 = {q_zero, q_one,  q_zero, q_zero};
    localparam row_t ident_row_2 = {q_zero, q_zero, q_one,  q_zero};
    localparam row_t ident_row_3 = {q_zero, q_zero, q_zero, q_one};

endpackage

`default_nettype wire

/* design/matrix_stack.sv */
`default_nettype none

module matrix_stack #(
    parameter int MV_DEPTH = 8,  // modelview matrices
    parameter int PJ_DEPTH = 2   // projection matrices
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire mat_pkg::mode_t    st_mode,    // stack being modified
    input  wire mat_pkg::mode_t    disp_mode,  // stack shown on top_row_*
    input  wire logic              push_req,
    input  wire logic              pop_req,
    input  wire logic              ident_req,
    input  wire logic              ld_we,
    input  wire mat_pkg::row_idx_t ld_idx,
    input  wire mat_pkg::row_t     ld_row,
    input  wire logic              res_we,
    input  wire mat_pkg::row_idx_t res_idx,
    input  wire mat_pkg::row_t     res_row,
    output mat_pkg::row_t          top_row_0,
    output mat_pkg::row_t          top_row_1,
    output mat_pkg::row_t          top_row_2,
    output mat_pkg::row_t          top_row_3,
    output logic                   err_flag    // push overflow / pop underflow
);

    // matrix-granular pointers, at least one bit
    localparam int mv_pw = (MV_DEPTH > 1) ? $clog2(MV_DEPTH) : 1;
    localparam int pj_pw = (PJ_DEPTH > 1) ? $clog2(PJ_DEPTH) : 1;

    typedef logic [mv_pw-1:0] mv_ptr_t;
    typedef logic [pj_pw-1:0] pj_ptr_t;

    localparam mv_ptr_t mv_last = mv_ptr_t'(MV_DEPTH - 1);  // highest legal level
    localparam pj_ptr_t pj_last = pj_ptr_t'(PJ_DEPTH - 1);

    // four rows per matrix, row address is {ptr, row}
    mat_pkg::row_t mv_mem [MV_DEPTH*4];
    mat_pkg::row_t pj_mem [PJ_DEPTH*4];

    mv_ptr_t mv_ptr;
    pj_ptr_t pj_ptr;
    mv_ptr_t mv_ptr_nx;  // level a push lands on
    pj_ptr_t pj_ptr_nx;

    assign mv_ptr_nx = mv_ptr + 1'b1;
    assign pj_ptr_nx = pj_ptr + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // stack updates, one request per cycle from the sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        err_flag <= 1'b0;  // single-cycle flag
        if (rst)
        begin
            mv_ptr    <= '0;
            pj_ptr    <= '0;
            mv_mem[0] <= mat_pkg::ident_row_0;  // one identity per stack
            mv_mem[1] <= mat_pkg::ident_row_1;
            mv_mem[2] <= mat_pkg::ident_row_2;
            mv_mem[3] <= mat_pkg::ident_row_3;
            pj_mem[0] <= mat_pkg::ident_row_0;
            pj_mem[1] <= mat_pkg::ident_row_1;
            pj_mem[2] <= mat_pkg::ident_row_2;
            pj_mem[3] <= mat_pkg::ident_row_3;
        end
        else if (st_mode == mat_pkg::mode_mv)
        begin
            if (push_req)
            begin
                if (mv_ptr == mv_last)
                    err_flag <= 1'b1;  // full, nothing moves
                else
                begin
                    for (int k = 0; k < 4; k++)
                        mv_mem[{mv_ptr_nx, 2'(k)}] <= mv_mem[{mv_ptr, 2'(k)}];
                    mv_ptr <= mv_ptr_nx;
                end
            end
            else if (pop_req)
            begin
                if (mv_ptr == '0)
                    err_flag <= 1'b1;  // last matrix stays
                else
                    mv_ptr <= mv_ptr - 1'b1;
            end
            else if (ident_req)
            begin
                mv_mem[{mv_ptr, 2'd0}] <= mat_pkg::ident_row_0;
                mv_mem[{mv_ptr, 2'd1}] <= mat_pkg::ident_row_1;
                mv_mem[{mv_ptr, 2'd2}] <= mat_pkg::ident_row_2;
                mv_mem[{mv_ptr, 2'd3}] <= mat_pkg::ident_row_3;
            end
            else if (ld_we)
                mv_mem[{mv_ptr, ld_idx}] <= ld_row;   // streamed load row
            else if (res_we)
                mv_mem[{mv_ptr, res_idx}] <= res_row; // multiply result row
        end
        else
        begin
            if (push_req)
            begin
                if (pj_ptr == pj_last)
                    err_flag <= 1'b1;
                else
                begin
                    for (int k = 0; k < 4; k++)
                        pj_mem[{pj_ptr_nx, 2'(k)}] <= pj_mem[{pj_ptr, 2'(k)}];
                    pj_ptr <= pj_ptr_nx;
                end
            end
            else if (pop_req)
            begin
                if (pj_ptr == '0)
                    err_flag <= 1'b1;
                else
                    pj_ptr <= pj_ptr - 1'b1;
            end
            else if (ident_req)
            begin
                pj_mem[{pj_ptr, 2'd0}] <= mat_pkg::ident_row_0;
                pj_mem[{pj_ptr, 2'd1}] <= mat_pkg::ident_row_1;
                pj_mem[{pj_ptr, 2'd2}] <= mat_pkg::ident_row_2;
                pj_mem[{pj_ptr, 2'd3}] <= mat_pkg::ident_row_3;
            end
            else if (ld_we)
                pj_mem[{pj_ptr, ld_idx}] <= ld_row;
            else if (res_we)
                pj_mem[{pj_ptr, res_idx}] <= res_row;
        end
    end

    // top of stack read-out, combinational
    always_comb
    begin
        if (disp_mode == mat_pkg::mode_pj)
        begin
            top_row_0 = pj_mem[{pj_ptr, 2'd0}];
            top_row_1 = pj_mem[{pj_ptr, 2'd1}];
            top_row_2 = pj_mem[{pj_ptr, 2'd2}];
            top_row_3 = pj_mem[{pj_ptr, 2'd3}];
        end
        else
        begin
            top_row_0 = mv_mem[{mv_ptr, 2'd0}];
            top_row_1 = mv_mem[{mv_ptr, 2'd1}];
            top_row_2 = mv_mem[{mv_ptr, 2'd2}];
            top_row_3 = mv_mem[{mv_ptr, 2'd3}];
        end
    end

endmodule

`default_nettype wire

/* design/matrix_mult.sv */
`default_nettype none

module matrix_mult (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              op_we,       // operand row strobe
    input  wire mat_pkg::row_idx_t op_idx,
    input  wire mat_pkg::row_t     op_row,
    input  wire logic              mult_start,  // with the fourth operand row
    input  wire mat_pkg::row_t     a_row_0,     // current top matrix
    input  wire mat_pkg::row_t     a_row_1,
    input  wire mat_pkg::row_t     a_row_2,
    input  wire mat_pkg::row_t     a_row_3,
    output logic                   res_we,
    output mat_pkg::row_idx_t      res_idx,
    output mat_pkg::row_t          res_row,
    output logic                   mult_done
);

    mat_pkg::row_t     op_buf [4];  // streamed right-hand matrix
    mat_pkg::row_t     a_sel;       // top row for the current output row
    mat_pkg::row_idx_t cnt;         // output row being written
    logic              active;
    logic signed [63:0] prod;       // full q32.32 product
    mat_pkg::elem_t    acc;

    // operand buffer
    always_ff @(posedge clk)
    begin
        if (op_we)
            op_buf[op_idx] <= op_row;
    end

    //////////////////////////////////////////////////////////////////////
    // row walk with one result row per cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active    <= 1'b0;
            cnt       <= '0;
            mult_done <= 1'b0;
        end
        else
        begin
            mult_done <= 1'b0;
            if (mult_start)
            begin
                active <= 1'b1;
                cnt    <= '0;
            end
            else if (active)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == 2'd3)
                begin
                    active    <= 1'b0;
                    mult_done <= 1'b1;  // cycle after last write
                end
            end
        end
    end

    assign res_we  = active;
    assign res_idx = cnt;

    always_comb
    begin
        case (cnt)
            2'd0:    a_sel = a_row_0;
            2'd1:    a_sel = a_row_1;
            2'd2:    a_sel = a_row_2;
            default: a_sel = a_row_3;
        endcase
    end

    // res[j] = sum_k a[k] * b[k][j] with each product cut to bits 47..16
    always_comb
    begin
        res_row = '0;
        prod    = '0;
        acc     = '0;
        for (int j = 0; j < 4; j++)
        begin
            acc = '0;
            for (int k = 0; k < 4; k++)
            begin
                prod = $signed(a_sel[127-32*k -: 32]) * $signed(op_buf[k][127-32*j -: 32]);
                acc  = acc + prod[47:16];  // wraps mod 2^32
            end
            res_row[127-32*j -: 32] = acc;
        end
    end

endmodule

`default_nettype wire

/* design/matrix_cmd.sv */
`default_nettype none

module matrix_cmd (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              cmd_valid,
    input  wire mat_pkg::mat_op_t  cmd_op,
    input  wire mat_pkg::mode_t    cmd_mode,
    input  wire logic              row_valid,
    input  wire logic              mult_done,
    output mat_pkg::mode_t         st_mode,    // latched for the whole command
    output logic                   push_req,
    output logic                   pop_req,
    output logic                   ident_req,
    output logic                   ld_we,
    output mat_pkg::row_idx_t      ld_idx,
    output logic                   op_we,
    output mat_pkg::row_idx_t      op_idx,
    output logic                   mult_start,
    output logic                   busy,
    output logic                   done
);

    typedef enum logic [1:0] {idle, load_rows, mult_rows, mult_run} state_t;

    state_t            state;
    mat_pkg::row_idx_t row_cnt;   // streamed rows taken so far
    logic              fin_pend;  // done goes out next cycle
    logic              accept;

    assign accept     = cmd_valid && !busy;  // overlapping commands dropped
    assign ld_we      = row_valid && (state == load_rows);
    assign ld_idx     = row_cnt;
    assign op_we      = row_valid && (state == mult_rows);
    assign op_idx     = row_cnt;
    assign mult_start = op_we && (row_cnt == 2'd3);  // fourth operand row

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= idle;
            row_cnt <= '0;
            st_mode <= mat_pkg::mode_mv;
            {push_req, pop_req, ident_req, fin_pend, busy, done} <= '0;
        end
        else
        begin
            {push_req, pop_req, ident_req, fin_pend} <= '0;  // strobes
            done <= fin_pend || ((state == mult_run) && mult_done);
            if (done)
                busy <= 1'b0;  // busy spans the done cycle
            if (ld_we || op_we)
                row_cnt <= row_cnt + 1'b1;
            case (state)
                idle:
                    if (accept)
                    begin
                        st_mode <= cmd_mode;
                        row_cnt <= '0;
                        case (cmd_op)
                            mat_pkg::op_load:
                            begin
                                state <= load_rows;
                                busy  <= 1'b1;
                            end
                            mat_pkg::op_mult:
                            begin
                                state <= mult_rows;
                                busy  <= 1'b1;
                            end
                            mat_pkg::op_push:
                            begin
                                push_req <= 1'b1;
                                fin_pend <= 1'b1;
                                busy     <= 1'b1;
                            end
                            mat_pkg::op_pop:
                            begin
                                pop_req  <= 1'b1;
                                fin_pend <= 1'b1;
                                busy     <= 1'b1;
                            end
                            mat_pkg::op_load_identity:
                            begin
                                ident_req <= 1'b1;
                                fin_pend  <= 1'b1;
                                busy      <= 1'b1;
                            end
                            default: ;  // unknown opcode ignored
                        endcase
                    end
                load_rows:
                    if (ld_we && (row_cnt == 2'd3))
                    begin
                        state    <= idle;
                        fin_pend <= 1'b1;  // last row written this edge
                    end
                mult_rows:
                    if (mult_start)
                        state <= mult_run;
                default:  // mult_run
                    if (mult_done)
                        state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/matrix_unit_top.sv */
`default_nettype none

module matrix_unit_top #(
    parameter int MV_DEPTH = 8,
    parameter int PJ_DEPTH = 2
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cmd_valid,
    input  wire mat_pkg::mat_op_t cmd_op,
    input  wire mat_pkg::mode_t   cmd_mode,
    input  wire logic             row_valid,
    input  wire mat_pkg::row_t    row_data,
    input  wire mat_pkg::mode_t   top_mode_sel,  // display select when idle
    output logic                  busy,
    output logic                  done,
    output logic                  err,
    output mat_pkg::row_t         top_row_0,
    output mat_pkg::row_t         top_row_1,
    output mat_pkg::row_t         top_row_2,
    output mat_pkg::row_t         top_row_3
);

    mat_pkg::mode_t    st_mode;
    mat_pkg::mode_t    disp_mode;
    logic              push_req;
    logic              pop_req;
    logic              ident_req;
    logic              ld_we;
    mat_pkg::row_idx_t ld_idx;
    logic              op_we;
    mat_pkg::row_idx_t op_idx;
    logic              mult_start;
    logic              mult_done;
    logic              res_we;
    mat_pkg::row_idx_t res_idx;
    mat_pkg::row_t     res_row;

    // the multiplier reads the display, so it must track st_mode while busy
    assign disp_mode = busy ? st_mode : top_mode_sel;

    //////////////////////////////////////////////////////////////////////
    // sequencer, stack, multiplier
    //////////////////////////////////////////////////////////////////////

    matrix_cmd u_cmd (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_mode(cmd_mode),
        .row_valid(row_valid), .mult_done(mult_done), .st_mode(st_mode),
        .push_req(push_req), .pop_req(pop_req), .ident_req(ident_req),
        .ld_we(ld_we), .ld_idx(ld_idx), .op_we(op_we), .op_idx(op_idx),
        .mult_start(mult_start), .busy(busy), .done(done)
    );

    matrix_stack #(.MV_DEPTH(MV_DEPTH), .PJ_DEPTH(PJ_DEPTH)) u_stack (
        .clk(clk), .rst(rst), .st_mode(st_mode), .disp_mode(disp_mode),
        .push_req(push_req), .pop_req(pop_req), .ident_req(ident_req),
        .ld_we(ld_we), .ld_idx(ld_idx), .ld_row(row_data),  // rows go straight in
        .res_we(res_we), .res_idx(res_idx), .res_row(res_row),
        .top_row_0(top_row_0), .top_row_1(top_row_1), .top_row_2(top_row_2),
        .top_row_3(top_row_3), .err_flag(err)
    );

    matrix_mult u_mult (
        .clk(clk), .rst(rst), .op_we(op_we), .op_idx(op_idx), .op_row(row_data),
        .mult_start(mult_start), .a_row_0(top_row_0), .a_row_1(top_row_1),
        .a_row_2(top_row_2), .a_row_3(top_row_3), .res_we(res_we),
        .res_idx(res_idx), .res_row(res_row), .mult_done(mult_done)
    );

endmodule

`default_nettype wire

/* verif/matrix_unit_tb.sv */
`default_nettype none

module matrix_unit_tb;

    localparam int mv_depth   = 8;   // uut built with default depths
    localparam int pj_depth   = 2;
    localparam int wait_limit = 50;  // cycles before giving up on done

    logic              clk = 1'b0;
    logic              rst;
    logic              cmd_valid;
    mat_pkg::mat_op_t  cmd_op;
    mat_pkg::mode_t    cmd_mode;
    logic              row_valid;
    mat_pkg::row_t     row_data;
    mat_pkg::mode_t    top_mode_sel;
    logic              busy;
    logic              done;
    logic              err;
    mat_pkg::row_t     top_row_0;
    mat_pkg::row_t     top_row_1;
    mat_pkg::row_t     top_row_2;
    mat_pkg::row_t     top_row_3;

    mat_pkg::row_t     model [2][mv_depth][4];  // projection uses the low levels only
    int                sp [2];                  // model stack pointers
    logic [31:0]       rng = 32'h851;

    always #5 clk = ~clk;

    matrix_unit_top uut (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_mode(cmd_mode),
        .row_valid(row_valid), .row_data(row_data), .top_mode_sel(top_mode_sel),
        .busy(busy), .done(done), .err(err), .top_row_0(top_row_0),
        .top_row_1(top_row_1), .top_row_2(top_row_2), .top_row_3(top_row_3)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference arithmetic
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic mat_pkg::row_t rand_row();
        mat_pkg::row_t r;
        logic [31:0]   x;
        for (int e = 0; e < 4; e++)
        begin
            x = next_rand();
            r[127-32*e -: 32] = {{12{x[19]}}, x[19:0]};  // within +-8.0
        end
        return r;
    endfunction

    function automatic int depth_of(mat_pkg::mode_t m);
        return (m == mat_pkg::mode_pj) ? pj_depth : mv_depth;
    endfunction

    // q16.16 product as bits 47..16 of the full result
    function automatic mat_pkg::elem_t q_mul(mat_pkg::elem_t a, mat_pkg::elem_t b);
        logic signed [63:0] p;
        p = $signed(a) * $signed(b);
        return p[47:16];
    endfunction

    // top <= top * b with sums wrapping mod 2^32
    task automatic model_mult(mat_pkg::mode_t m, input mat_pkg::row_t b [4]);
        mat_pkg::row_t  a [4];
        mat_pkg::elem_t acc;
        for (int i = 0; i < 4; i++)
            a[i] = model[m][sp[m]][i];
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
            begin
                acc = '0;
                for (int k = 0; k < 4; k++)
                    acc = acc + q_mul(a[i][127-32*k -: 32], b[k][127-32*j -: 32]);
                model[m][sp[m]][i][127-32*j -: 32] = acc;
            end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic fail_stop(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_row(mat_pkg::row_t got, mat_pkg::row_t exp, string what);
        if (got !== exp)
            fail_stop($sformatf("ERROR @%0t: %s row %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp)
            fail_stop($sformatf("ERROR @%0t: %s flag %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp)
            fail_stop($sformatf("ERROR @%0t: %s took %0d cycles, expected %0d",
                                $time, what, got, exp));
    endtask

    task automatic check_top(mat_pkg::mode_t m, string what);
        check_row(top_row_0, model[m][sp[m]][0], {what, " top row 0"});
        check_row(top_row_1, model[m][sp[m]][1], {what, " top row 1"});
        check_row(top_row_2, model[m][sp[m]][2], {what, " top row 2"});
        check_row(top_row_3, model[m][sp[m]][3], {what, " top row 3"});
    endtask

    //////////////////////////////////////////////////////////////////////
    // inputs change on the rising edge and outputs are read on the falling
    //////////////////////////////////////////////////////////////////////

    task automatic issue_cmd(mat_pkg::mat_op_t op, mat_pkg::mode_t m);
        @(posedge clk);
        cmd_valid    <= 1'b1;
        cmd_op       <= op;
        cmd_mode     <= m;
        top_mode_sel <= m;
        @(posedge clk);     // sampling edge
        cmd_valid    <= 1'b0;
    endtask

    task automatic send_row(mat_pkg::row_t r, int gap);
        repeat (gap) @(posedge clk);  // idle cycles between rows
        @(posedge clk);
        row_valid <= 1'b1;
        row_data  <= r;
        @(posedge clk);
        row_valid <= 1'b0;
    endtask

    // rising edges from the sampling edge to done
    task automatic wait_done(string what, output int cycles, output logic err_seen);
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < wait_limit)
        begin
            cycles++;
            @(negedge clk);
        end
        if (!done)
            fail_stop($sformatf("done never came for %s within %0d cycles", what, wait_limit));
        err_seen = err;
        check_flag(busy, 1'b1, {what, " busy at done"});  // busy spans done
    endtask

    task automatic run_simple(mat_pkg::mat_op_t op, mat_pkg::mode_t m, string what);
        logic exp_err;
        logic err_seen;
        int   cycles;
        exp_err = (op == mat_pkg::op_push && sp[m] == depth_of(m) - 1) ||
                  (op == mat_pkg::op_pop && sp[m] == 0);
        issue_cmd(op, m);
        wait_done(what, cycles, err_seen);
        check_count(cycles, 1, what);
        check_flag(err_seen, exp_err, {what, " err"});
        if (!exp_err)
        begin
            case (op)
                mat_pkg::op_push:
                begin
                    for (int i = 0; i < 4; i++)
                        model[m][sp[m]+1][i] = model[m][sp[m]][i];
                    sp[m]++;
                end
                mat_pkg::op_pop:
                    sp[m]--;
                default:
                begin
                    model[m][sp[m]][0] = mat_pkg::ident_row_0;
                    model[m][sp[m]][1] = mat_pkg::ident_row_1;
                    model[m][sp[m]][2] = mat_pkg::ident_row_2;
                    model[m][sp[m]][3] = mat_pkg::ident_row_3;
                end
            endcase
        end
        check_top(m, what);  // refused commands leave the top alone
    endtask

    // load or multiply with four rows and random gaps
    task automatic run_stream(mat_pkg::mat_op_t op, mat_pkg::mode_t m, string what);
        mat_pkg::row_t rows [4];
        logic          err_seen;
        int            cycles;
        for (int i = 0; i < 4; i++)
            rows[i] = rand_row();
        issue_cmd(op, m);
        for (int i = 0; i < 4; i++)
            send_row(rows[i], 1 + int'(next_rand() % 3));
        wait_done(what, cycles, err_seen);
        check_count(cycles, (op == mat_pkg::op_mult) ? 5 : 1, what);
        check_flag(err_seen, 1'b0, {what, " err"});
        if (op == mat_pkg::op_mult)
            model_mult(m, rows);
        else
            for (int i = 0; i < 4; i++)
                model[m][sp[m]][i] = rows[i];
        check_top(m, what);
    endtask

    // idle display of one stack with no strobes pending
    task automatic show_idle(mat_pkg::mode_t m, string what);
        @(posedge clk);
        top_mode_sel <= m;
        @(negedge clk);
        check_flag(busy, 1'b0, {what, " busy"});
        check_flag(done, 1'b0, {what, " done"});
        check_flag(err, 1'b0, {what, " err"});
        check_top(m, what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        show_idle(mat_pkg::mode_mv, "reset modelview");
        show_idle(mat_pkg::mode_pj, "reset projection");
    endtask

    task automatic test_load();
        for (int m = 0; m < 2; m++)
        begin
            run_stream(mat_pkg::op_load, mat_pkg::mode_t'(m), "load");
            show_idle(mat_pkg::mode_t'(1 - m), "load other stack");
        end
    endtask

    task automatic test_push_pop(mat_pkg::mode_t m);
        run_simple(mat_pkg::op_push, m, "push");
        run_stream(mat_pkg::op_load, m, "load after push");
        run_simple(mat_pkg::op_pop, m, "pop");  // old matrix back
        run_simple(mat_pkg::op_load_identity, m, "load identity");
        show_idle(m, "after identity");
    endtask

    task automatic test_limits(mat_pkg::mode_t m);
        while (sp[m] < depth_of(m) - 1)
            run_simple(mat_pkg::op_push, m, "push to full");
        run_stream(mat_pkg::op_load, m, "load at full");
        run_simple(mat_pkg::op_push, m, "push overflow");
        while (sp[m] > 0)
            run_simple(mat_pkg::op_pop, m, "pop to bottom");
        run_simple(mat_pkg::op_pop, m, "pop underflow");
        show_idle(m, "after limits");
    endtask

    task automatic test_mult(mat_pkg::mode_t m);
        run_stream(mat_pkg::op_load, m, "load before multiply");
        run_stream(mat_pkg::op_mult, m, "multiply");
        run_stream(mat_pkg::op_mult, m, "second multiply");
        show_idle(m, "after multiply");
    endtask

    initial
    begin
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = mat_pkg::op_load_identity;
        cmd_mode     = mat_pkg::mode_mv;
        row_valid    = 1'b0;
        row_data     = '0;
        top_mode_sel = mat_pkg::mode_mv;
        for (int m = 0; m < 2; m++)
        begin
            sp[m]       = 0;
            model[m][0][0] = mat_pkg::ident_row_0;  // one identity per stack
            model[m][0][1] = mat_pkg::ident_row_1;
            model[m][0][2] = mat_pkg::ident_row_2;
            model[m][0][3] = mat_pkg::ident_row_3;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_load();
        test_push_pop(mat_pkg::mode_mv);
        test_push_pop(mat_pkg::mode_pj);
        test_limits(mat_pkg::mode_mv);
        test_limits(mat_pkg::mode_pj);
        test_mult(mat_pkg::mode_mv);
        test_mult(mat_pkg::mode_pj);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/mat_pkg.sv
design/matrix_stack.sv
design/matrix_mult.sv
design/matrix_cmd.sv
design/matrix_unit_top.sv
verif/matrix_unit_tb.sv

/* Bender.yml */
package:
  name: matrix_unit

sources:
  - files:
      - design/mat_pkg.sv
      - design/matrix_stack.sv
      - design/matrix_mult.sv
      - design/matrix_cmd.sv
      - design/matrix_unit_top.sv
  - target: simulation
    files:
      - verif/matrix_unit_tb.sv
